// ==== list.f ====
+incdir+hw
hw/gpio_slave_pkg.sv
hw/bus_cycle_ctrl.sv
hw/gpo_reg_bank.sv
hw/read_return.sv
hw/gpio_bus_slave.sv
bench/gpio_bus_slave_tb.sv

// ==== bench/gpio_bus_slave_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gpio_slave_settings.svh"

module gpio_bus_slave_tb;
	import gpio_slave_pkg::*;

	localparam int N_TXN = 44;                        // bus accesses issued below
	localparam int WATCHDOG_CYCLES = N_TXN * 8 + 50;
	localparam int MAX_EDGES = 16;                    // per access before giving up
	localparam logic [31:0] SEED = 32'hd01b_2859;

	// what the bus task saw for one access
	typedef struct packed {
		logic                    rnw;
		logic [`GPIO_DATA_W-1:0] addr;
		logic [`GPIO_DATA_W-1:0] wdata;
		logic [`GPIO_PORT_W-1:0] ip;              // gp_ip during the access
		logic [7:0]              edges;           // valid edges until ready
		logic                    timed_out;
		bus_rsp_t                rsp;             // sampled in the ready cycle
		logic [`GPIO_PORT_W-1:0] gp_op;
		logic [`GPIO_WORDS-1:0]  valid_at_ready;
		logic [`GPIO_WORDS-1:0]  valid_other;     // any pulse outside ready
		logic                    ready_after;
	} obs_t;

	// what the access should have produced
	typedef struct packed {
		logic [7:0]              edges;
		logic                    error;
		logic                    check_rd;        // read_data defined
		logic [`GPIO_DATA_W-1:0] read_data;
		logic [`GPIO_PORT_W-1:0] gp_op;
		logic [`GPIO_WORDS-1:0]  valid_pulse;
	} exp_t;

	logic                    BUS_agnt_vi;
	logic                    reset;
	bus_req_t                bus_req;
	bus_rsp_t                bus_rsp;
	logic [`GPIO_PORT_W-1:0] gp_ip;
	logic [`GPIO_PORT_W-1:0] gp_op;
	logic [`GPIO_WORDS-1:0]  gp_op_valid;

	obs_t                    obs_q[$];           // bus task to checker
	int                      error_count = 0;
	int                      issued = 0;
	int                      checked = 0;

	gpio_bus_slave gpio_bus_slave_inst (
		.BUS_agnt_vi (BUS_agnt_vi),
		.reset       (reset),
		.bus_req     (bus_req),
		.bus_rsp     (bus_rsp),
		.gp_ip       (gp_ip),
		.gp_op       (gp_op),
		.gp_op_valid (gp_op_valid)
	);

	initial BUS_agnt_vi = 1'b0;
	always #50 BUS_agnt_vi = ~BUS_agnt_vi;       // 100 ns period

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////
	function automatic exp_t expect_response(input logic rnw,
			input logic [`GPIO_DATA_W-1:0] addr, input logic [`GPIO_DATA_W-1:0] wdata,
			input logic [`GPIO_PORT_W-1:0] shadow, input logic [`GPIO_PORT_W-1:0] ip);
		exp_t                    e;
		logic                    in_gpo;
		logic                    in_gpi;
		int                      idx;
		logic [`GPIO_PORT_W-1:0] port;
		logic [`GPIO_WORDS-1:0]  pulse;
		// each range is eight aligned words from its base
		in_gpo = addr >= `GPO_BASE && addr < `GPO_BASE + 4 * `GPIO_WORDS && addr[1:0] == 2'b00;
		in_gpi = addr >= `GPI_BASE && addr < `GPI_BASE + 4 * `GPIO_WORDS && addr[1:0] == 2'b00;
		idx    = in_gpo ? int'((addr - `GPO_BASE) / 4) : int'((addr - `GPI_BASE) / 4);
		port   = shadow;
		pulse  = '0;
		e.edges     = rnw ? 8'(`RD_WAIT + 1) : 8'(`WR_WAIT + 1);
		e.error     = 1'b0;
		e.check_rd  = 1'b1;
		e.read_data = '0;
		if (!rnw) begin
			if (in_gpo) begin
				port[idx*`GPIO_DATA_W +: `GPIO_DATA_W] = wdata;
				pulse[idx] = 1'b1;
				e.check_rd = 1'b0;                 // old read data stays
			end else begin
				e.error = 1'b1;                    // gpi is read only
			end
		end else if (in_gpo) begin
			e.read_data = shadow[idx*`GPIO_DATA_W +: `GPIO_DATA_W];
		end else if (in_gpi) begin
			e.read_data = ip[idx*`GPIO_DATA_W +: `GPIO_DATA_W];
		end else begin
			e.error = 1'b1;
		end
		e.gp_op       = port;
		e.valid_pulse = pulse;
		return e;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// bus master
	////////////////////////////////////////////////////////////////////////////
	// entered and left 1 ns after a rising edge
	task automatic bus_access(input logic rnw, input logic [`GPIO_DATA_W-1:0] addr,
			input logic [`GPIO_DATA_W-1:0] wdata);
		obs_t o;
		logic seen;
		o = '0;
		o.rnw   = rnw;
		o.addr  = addr;
		o.wdata = wdata;
		o.ip    = gp_ip;
		seen    = 1'b0;
		bus_req = '{valid: 1'b1, rnw: rnw, addr: addr, write_data: wdata};
		while (!seen && o.edges < MAX_EDGES) begin
			@(posedge BUS_agnt_vi);
			#1;
			o.edges++;
			if (bus_rsp.ready) begin
				seen             = 1'b1;
				o.rsp            = bus_rsp;
				o.gp_op          = gp_op;
				o.valid_at_ready = gp_op_valid;
			end else begin
				o.valid_other |= gp_op_valid;
			end
		end
		o.timed_out = !seen;
		@(posedge BUS_agnt_vi);                      // master sees ready here
		#1;
		bus_req.valid = 1'b0;
		o.ready_after  = bus_rsp.ready;
		o.valid_other |= gp_op_valid;
		@(posedge BUS_agnt_vi);                      // slave recovers
		#1;
		o.valid_other |= gp_op_valid;
		issued++;
		obs_q.push_back(o);
	endtask

	task automatic drive_random_gp_ip();
		for (int i = 0; i < `GPIO_WORDS; i++) begin
			gp_ip[i*`GPIO_DATA_W +: `GPIO_DATA_W] = $urandom;
		end
	endtask

	// anything clear of both ranges
	function automatic logic [`GPIO_DATA_W-1:0] outside_addr();
		logic [`GPIO_DATA_W-1:0] a;
		a = $urandom;
		while (a >= `GPO_BASE && a < `GPI_BASE + 4 * `GPIO_WORDS) begin
			a = $urandom;
		end
		return a;
	endfunction

	task automatic check_reset_state();
		if (bus_rsp.ready !== 1'b0) begin
			$display("CHECK FAILED bus_rsp.ready after reset expected %h got %h",
				1'b0, bus_rsp.ready);
			error_count++;
		end
		if (bus_rsp.error !== 1'b0) begin
			$display("CHECK FAILED bus_rsp.error after reset expected %h got %h",
				1'b0, bus_rsp.error);
			error_count++;
		end
		if (bus_rsp.read_data !== '0) begin
			$display("CHECK FAILED bus_rsp.read_data after reset expected %h got %h",
				{`GPIO_DATA_W{1'b0}}, bus_rsp.read_data);
			error_count++;
		end
		if (gp_op !== '0) begin
			$display("CHECK FAILED gp_op after reset expected %h got %h",
				{`GPIO_PORT_W{1'b0}}, gp_op);
			error_count++;
		end
		if (gp_op_valid !== '0) begin
			$display("CHECK FAILED gp_op_valid after reset expected %h got %h",
				{`GPIO_WORDS{1'b0}}, gp_op_valid);
			error_count++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// checker
	////////////////////////////////////////////////////////////////////////////
	initial begin
		obs_t                    o;
		exp_t                    e;
		logic [`GPIO_PORT_W-1:0] shadow;
		shadow = '0;                                 // port is zero after reset
		forever begin
			wait (obs_q.size() != 0);
			o = obs_q.pop_front();
			e = expect_response(o.rnw, o.addr, o.wdata, shadow, o.ip);
			if (o.timed_out) begin
				$display("DUT gave no ready for the access to address %h", o.addr);
				error_count++;
			end else begin
				if (o.edges !== e.edges) begin
					$display("CHECK FAILED ready latency addr %h expected %h got %h",
						o.addr, e.edges, o.edges);
					error_count++;
				end
				if (o.rsp.error !== e.error) begin
					$display("CHECK FAILED bus_rsp.error addr %h expected %h got %h",
						o.addr, e.error, o.rsp.error);
					error_count++;
				end
				if (e.check_rd && o.rsp.read_data !== e.read_data) begin
					$display("CHECK FAILED bus_rsp.read_data addr %h expected %h got %h",
						o.addr, e.read_data, o.rsp.read_data);
					error_count++;
				end
				if (o.gp_op !== e.gp_op) begin
					$display("CHECK FAILED gp_op addr %h expected %h got %h",
						o.addr, e.gp_op, o.gp_op);
					error_count++;
				end
				if (o.valid_at_ready !== e.valid_pulse) begin
					$display("CHECK FAILED gp_op_valid addr %h expected %h got %h",
						o.addr, e.valid_pulse, o.valid_at_ready);
					error_count++;
				end
			end
			if (o.valid_other !== '0) begin
				$display("CHECK FAILED gp_op_valid outside ready addr %h expected %h got %h",
					o.addr, {`GPIO_WORDS{1'b0}}, o.valid_other);
				error_count++;
			end
			if (o.ready_after !== 1'b0) begin
				$display("CHECK FAILED bus_rsp.ready second cycle addr %h expected %h got %h",
					o.addr, 1'b0, o.ready_after);
				error_count++;
			end
			shadow = e.gp_op;
			checked++;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////
	initial begin
		int order [`GPIO_WORDS];
		int j;
		int tmp;
		void'($urandom(SEED));
		reset   = 1'b1;
		bus_req = '0;
		gp_ip   = '0;
		repeat (10) @(posedge BUS_agnt_vi);
		#1;
		reset = 1'b0;
		check_reset_state();
		@(posedge BUS_agnt_vi);
		#1;

		// gpo writes in shuffled word order
		for (int i = 0; i < `GPIO_WORDS; i++) begin
			order[i] = i;
		end
		for (int i = `GPIO_WORDS - 1; i > 0; i--) begin
			j        = $urandom_range(i, 0);
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < `GPIO_WORDS; i++) begin
			bus_access(1'b0, 32'(`GPO_BASE + 4 * order[i]), $urandom);
		end

		for (int i = 0; i < `GPIO_WORDS; i++) begin
			bus_access(1'b1, 32'(`GPO_BASE + 4 * i), '0);   // readback
		end

		drive_random_gp_ip();
		for (int i = 0; i < `GPIO_WORDS; i++) begin
			bus_access(1'b1, 32'(`GPI_BASE + 4 * i), '0);
		end

		// illegal writes must not move the port
		for (int i = 0; i < 4; i++) begin
			bus_access(1'b0, 32'(`GPI_BASE + 4 * $urandom_range(7, 0)), $urandom);
		end
		for (int i = 0; i < 4; i++) begin
			bus_access(1'b0, 32'(`GPO_BASE + 4 * i + (i % 3) + 1), $urandom);   // unaligned
		end
		for (int i = 0; i < 4; i++) begin
			bus_access(1'b0, outside_addr(), $urandom);
		end

		// each illegal read follows a good read that leaves nonzero data
		bus_access(1'b1, 32'(`GPI_BASE), '0);
		bus_access(1'b1, outside_addr(), '0);
		bus_access(1'b1, 32'(`GPO_BASE + 4), '0);
		bus_access(1'b1, 32'(`GPO_BASE + 6), '0);
		bus_access(1'b1, 32'(`GPI_BASE + 8), '0);
		bus_access(1'b1, 32'(`GPI_BASE + 4 * `GPIO_WORDS), '0);   // just past gpi
		bus_access(1'b1, 32'(`GPO_BASE + 12), '0);
		bus_access(1'b1, outside_addr(), '0);

		wait (checked == issued);
		$display("%0d accesses checked, %0d errors", checked, error_count);
		if (error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge BUS_agnt_vi);
		$display("run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

endmodule: gpio_bus_slave_tb

`default_nettype wire

// ==== hw/gpio_bus_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gpio_slave_settings.svh"

module gpio_bus_slave (
	input  logic                     BUS_agnt_vi,
	input  logic                     reset,
	input  gpio_slave_pkg::bus_req_t bus_req,
	output gpio_slave_pkg::bus_rsp_t bus_rsp,
	input  logic [`GPIO_PORT_W-1:0]  gp_ip,
	output logic [`GPIO_PORT_W-1:0]  gp_op,
	output logic [`GPIO_WORDS-1:0]   gp_op_valid
);
	import gpio_slave_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// internal wires
	////////////////////////////////////////////////////////////////////////////
	logic                    wr_stb;
	logic                    rd_stb;
	logic                    err_stb;
	logic [`GPIO_SEL_W-1:0]  word_sel;  // word index of the current access
	region_e                 region;
	logic                    ready;
	logic                    error;
	logic [`GPIO_DATA_W-1:0] read_data;

	////////////////////////////////////////////////////////////////////////////
	// bus cycle controller
	////////////////////////////////////////////////////////////////////////////
	// decode, wait states, ready and error
	bus_cycle_ctrl bus_cycle_ctrl_inst (
		.BUS_agnt_vi (BUS_agnt_vi),
		.reset       (reset),
		.bus_req     (bus_req),
		.wr_stb      (wr_stb),
		.rd_stb      (rd_stb),
		.err_stb     (err_stb),
		.word_sel    (word_sel),
		.region      (region),
		.ready       (ready),
		.error       (error)
	);

	////////////////////////////////////////////////////////////////////////////
	// output registers
	////////////////////////////////////////////////////////////////////////////
	gpo_reg_bank gpo_reg_bank_inst (
		.BUS_agnt_vi (BUS_agnt_vi),
		.reset       (reset),
		.wr_stb      (wr_stb),
		.word_sel    (word_sel),
		.write_data  (bus_req.write_data),  // held by master until ready
		.gp_op       (gp_op),
		.gp_op_valid (gp_op_valid)
	);

	////////////////////////////////////////////////////////////////////////////
	// read path
	////////////////////////////////////////////////////////////////////////////
	read_return read_return_inst (
		.BUS_agnt_vi (BUS_agnt_vi),
		.reset       (reset),
		.rd_stb      (rd_stb),
		.err_stb     (err_stb),
		.region      (region),
		.word_sel    (word_sel),
		.gp_op       (gp_op),              // readback taps the port itself
		.gp_ip       (gp_ip),
		.read_data   (read_data)
	);

	// all three fields change on the same edge
	assign bus_rsp = '{
		ready:     ready,
		error:     error,
		read_data: read_data
	};

endmodule: gpio_bus_slave

`default_nettype wire

// ==== hw/read_return.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gpio_slave_settings.svh"

module read_return (
	input  logic                     BUS_agnt_vi,
	input  logic                     reset,
	input  logic                     rd_stb,       // capture selected word
	input  logic                     err_stb,      // out of range, return zero
	input  gpio_slave_pkg::region_e  region,
	input  logic [`GPIO_SEL_W-1:0]   word_sel,
	input  logic [`GPIO_PORT_W-1:0]  gp_op,        // readback of the output port
	input  logic [`GPIO_PORT_W-1:0]  gp_ip,
	output logic [`GPIO_DATA_W-1:0]  read_data
);
	import gpio_slave_pkg::*;

	logic [`GPIO_DATA_W-1:0] gpo_word;
	logic [`GPIO_DATA_W-1:0] gpi_word;
	logic [`GPIO_DATA_W-1:0] sel_word;

	////////////////////////////////////////////////////////////////////////////
	// source select
	////////////////////////////////////////////////////////////////////////////
	assign gpo_word = gp_op[word_sel*`GPIO_DATA_W +: `GPIO_DATA_W];
	assign gpi_word = gp_ip[word_sel*`GPIO_DATA_W +: `GPIO_DATA_W];

	always_comb begin
		case (region)
			REG_GPO: sel_word = gpo_word;
			REG_GPI: sel_word = gpi_word;  // sampled at the strobe edge
			default: sel_word = '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// read data register
	////////////////////////////////////////////////////////////////////////////
	// updates on the edge that raises ready, holds otherwise
	always_ff @(posedge BUS_agnt_vi) begin
		if (reset) begin
			read_data <= '0;
		end else if (err_stb) begin
			read_data <= '0;               // error wins
		end else if (rd_stb) begin
			read_data <= sel_word;
		end
	end

endmodule: read_return

`default_nettype wire

// ==== hw/gpo_reg_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gpio_slave_settings.svh"

module gpo_reg_bank (
	input  logic                     BUS_agnt_vi,
	input  logic                     reset,
	input  logic                     wr_stb,       // one cycle pulse from the controller
	input  logic [`GPIO_SEL_W-1:0]   word_sel,
	input  logic [`GPIO_DATA_W-1:0]  write_data,
	output logic [`GPIO_PORT_W-1:0]  gp_op,
	output logic [`GPIO_WORDS-1:0]   gp_op_valid   // per word update pulse
);

	////////////////////////////////////////////////////////////////////////////
	// output word storage
	////////////////////////////////////////////////////////////////////////////
	logic [`GPIO_DATA_W-1:0] gpo_word [`GPIO_WORDS];
	logic [`GPIO_WORDS-1:0]  sel_onehot;

	// one hot on the addressed word
	assign sel_onehot = `GPIO_WORDS'(1) << word_sel;

	// eight words, loaded one at a time
	always_ff @(posedge BUS_agnt_vi) begin
		if (reset) begin
			for (int i = 0; i < `GPIO_WORDS; i++) begin
				gpo_word[i] <= '0;
			end
		end else if (wr_stb) begin
			gpo_word[word_sel] <= write_data;  // other words hold
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// valid pulse
	////////////////////////////////////////////////////////////////////////////
	// high for the single cycle in which the new word appears
	always_ff @(posedge BUS_agnt_vi) begin
		if (reset) begin
			gp_op_valid <= '0;
		end else if (wr_stb) begin
			gp_op_valid <= sel_onehot;
		end else begin
			gp_op_valid <= '0;               // self clearing
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// port packing
	////////////////////////////////////////////////////////////////////////////
	// word 0 sits in the low bits of the port
	for (genvar g = 0; g < `GPIO_WORDS; g++) begin : g_pack
		assign gp_op[g*`GPIO_DATA_W +: `GPIO_DATA_W] = gpo_word[g];
	end

endmodule: gpo_reg_bank

`default_nettype wire

// ==== hw/bus_cycle_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gpio_slave_settings.svh"

module bus_cycle_ctrl (
	input  logic                     BUS_agnt_vi,
	input  logic                     reset,
	input  gpio_slave_pkg::bus_req_t bus_req,
	output logic                     wr_stb,    // gpo word load
	output logic                     rd_stb,    // read data capture
	output logic                     err_stb,   // clear read data
	output logic [`GPIO_SEL_W-1:0]   word_sel,
	output gpio_slave_pkg::region_e  region,
	output logic                     ready,
	output logic                     error
);
	import gpio_slave_pkg::*;

	// counter must hold the larger of the two wait counts
	localparam int MAX_WAIT = (`WR_WAIT > `RD_WAIT) ? `WR_WAIT : `RD_WAIT;
	localparam int CNT_W = $clog2(MAX_WAIT + 1);
	localparam int OFS_W = `GPIO_SEL_W + 2;    // byte offset bits of one range

	ctrl_state_e             state;
	logic [CNT_W-1:0]        wait_cnt;         // remaining wait states
	bus_op_e                 req_op;
	bus_op_e                 op_q;             // op of the accepted request
	region_e                 dec_region;
	logic [`GPIO_SEL_W-1:0]  dec_sel;
	logic [`GPIO_DATA_W-1:0] gpo_ofs;
	logic [`GPIO_DATA_W-1:0] gpi_ofs;
	logic                    last_wait;        // strobe cycle
	logic                    bad_access;

	////////////////////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////////////////////
	assign req_op  = bus_op_e'(bus_req.rnw);
	assign gpo_ofs = bus_req.addr - `GPO_BASE;
	assign gpi_ofs = bus_req.addr - `GPI_BASE;

	// full 32 bit compare, unaligned counts as outside
	always_comb begin
		dec_region = REG_NONE;
		dec_sel    = '0;
		if (gpo_ofs[`GPIO_DATA_W-1:OFS_W] == '0 && gpo_ofs[1:0] == 2'b00) begin
			dec_region = REG_GPO;
			dec_sel    = gpo_ofs[OFS_W-1:2];
		end else if (gpi_ofs[`GPIO_DATA_W-1:OFS_W] == '0 && gpi_ofs[1:0] == 2'b00) begin
			dec_region = REG_GPI;
			dec_sel    = gpi_ofs[OFS_W-1:2];
		end
	end

	// address is stable while valid, so take it once at accept
	always_ff @(posedge BUS_agnt_vi) begin
		if (state == IDLE && bus_req.valid) begin
			op_q     <= req_op;
			region   <= dec_region;
			word_sel <= dec_sel;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// strobes
	////////////////////////////////////////////////////////////////////////////
	assign last_wait = (state == WAIT) && (wait_cnt == '0);

	// writes only land in the gpo range
	assign bad_access = (region == REG_NONE) || (op_q == OP_WRITE && region != REG_GPO);

	assign wr_stb  = last_wait && op_q == OP_WRITE && region == REG_GPO;
	assign rd_stb  = last_wait && op_q == OP_READ && region != REG_NONE;
	assign err_stb = last_wait && bad_access;

	////////////////////////////////////////////////////////////////////////////
	// cycle FSM
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge BUS_agnt_vi) begin
		if (reset) begin
			state    <= IDLE;
			wait_cnt <= '0;
			ready    <= 1'b0;
			error    <= 1'b0;
		end else begin
			ready <= 1'b0;                 // single cycle response
			error <= 1'b0;
			case (state)
				IDLE: begin
					if (bus_req.valid) begin
						state <= WAIT;
						// accept edge is the first of the wait-plus-one edges
						if (req_op == OP_WRITE) begin
							wait_cnt <= CNT_W'(`WR_WAIT - 1);
						end else begin
							wait_cnt <= CNT_W'(`RD_WAIT - 1);
						end
					end
				end
				WAIT: begin
					if (last_wait) begin
						state <= RESP;
						ready <= 1'b1;         // same edge as the data update
						error <= bad_access;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				RESP: state <= RECOVER;      // ready seen by master here
				RECOVER: state <= IDLE;      // master drops valid meanwhile
				default: state <= IDLE;
			endcase
		end
	end

endmodule: bus_cycle_ctrl

`default_nettype wire

// ==== hw/gpio_slave_pkg.sv ====
`default_nettype none

`include "gpio_slave_settings.svh"

package gpio_slave_pkg;

	////////////////////////////////////////////////////////////////////////////
	// bus request and response
	////////////////////////////////////////////////////////////////////////////
	// master side, held stable until ready is seen
	typedef struct packed {
		logic                    valid;
		logic                    rnw;        // 1 read, 0 write
		logic [`GPIO_DATA_W-1:0] addr;       // byte address
		logic [`GPIO_DATA_W-1:0] write_data;
	} bus_req_t;

	// slave side, one cycle wide
	typedef struct packed {
		logic                    ready;
		logic                    error;
		logic [`GPIO_DATA_W-1:0] read_data;  // zero on error
	} bus_rsp_t;

	////////////////////////////////////////////////////////////////////////////
	// enums
	////////////////////////////////////////////////////////////////////////////
	// encoding follows rnw
	typedef enum logic {OP_WRITE = 1'b0, OP_READ = 1'b1} bus_op_e;

	// address decode result
	typedef enum logic [1:0] {REG_GPO, REG_GPI, REG_NONE} region_e;

	// bus cycle controller
	typedef enum logic [1:0] {IDLE, WAIT, RESP, RECOVER} ctrl_state_e;

endpackage: gpio_slave_pkg

`default_nettype wire

// ==== hw/gpio_slave_settings.svh ====
`ifndef GPIO_SLAVE_SETTINGS_SVH
`define GPIO_SLAVE_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// bus and port geometry
////////////////////////////////////////////////////////////////////////////
`define GPIO_DATA_W 32           // bus word
`define GPIO_WORDS 8             // words per gpio port
`define GPIO_SEL_W 3             // word index bits
`define GPIO_PORT_W 256          // GPIO_WORDS x GPIO_DATA_W

////////////////////////////////////////////////////////////////////////////
// address map and wait states
////////////////////////////////////////////////////////////////////////////
// both ranges are eight aligned words
`define GPO_BASE 32'h0100_0000   // output words, read and write
`define GPI_BASE 32'h0100_0020   // input words, read only

`define WR_WAIT 2                // wait states for a write
`define RD_WAIT 3                // wait states for a read

`endif
